//--- design/rename_pkg.sv
package rename_pkg;

    // Instruction and architectural register file geometry
    localparam int XLEN_W     = 32;
    localparam int AREG_W     = 5;
    localparam int AREG_COUNT = 32;

    // Opcodes the rename front end tells apart
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111
    } opcode_e;

    typedef struct packed {
        logic [6:0]        funct7;
        logic [AREG_W-1:0] rs2;
        logic [AREG_W-1:0] rs1;
        logic [2:0]        funct3;
        logic [AREG_W-1:0] rd;
        opcode_e           opcode;
    } r_type_t;

    // Bits 11:7 hold immediate bits here, not a destination
    typedef struct packed {
        logic [6:0]        imm_hi;
        logic [AREG_W-1:0] rs2;
        logic [AREG_W-1:0] rs1;
        logic [2:0]        funct3;
        logic [4:0]        imm_lo;
        opcode_e           opcode;
    } s_type_t;

    typedef union packed {
        r_type_t r;
        s_type_t s;
    } inst_u;

    // Index width for a table of the given size
    function automatic int preg_w(input int count);
        return (count > 1) ? $clog2(count) : 1;
    endfunction

    // After reset architectural register i lives in physical register i
    function automatic int reset_map(input int areg);
        return areg;
    endfunction

    // Free list slot n starts out holding the first unmapped register plus n
    function automatic int reset_free(input int slot);
        return AREG_COUNT + slot;
    endfunction

endpackage

//--- design/inst_decode.sv
module inst_decode (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            inst_valid,
    input  rename_pkg::inst_u               inst,
    input  logic                            free_avail,
    input  logic                            rob_avail,
    output logic                            stall,
    output logic                            dec_valid,
    output logic [rename_pkg::AREG_W-1:0]   dec_rs1,
    output logic [rename_pkg::AREG_W-1:0]   dec_rs2,
    output logic [rename_pkg::AREG_W-1:0]   dec_rd,
    output logic                            dec_use_rs1,
    output logic                            dec_use_rs2,
    output logic                            dec_has_rd
);

    logic                          accept;
    logic                          use_rs1;
    logic                          use_rs2;
    logic                          has_rd;

    assign stall  = !(free_avail && rob_avail);
    assign accept = inst_valid && !stall;

    always_comb begin
        use_rs1  = 1'b1;
        use_rs2  = 1'b0;
        has_rd   = 1'b1;
        case (inst.r.opcode)
            rename_pkg::OP: begin
                use_rs2 = 1'b1;
            end
            rename_pkg::OP_IMM, rename_pkg::LOAD: begin
                use_rs1 = 1'b1;
            end
            rename_pkg::STORE, rename_pkg::BRANCH: begin
                use_rs2  = 1'b1;
                has_rd   = 1'b0;
            end
            rename_pkg::LUI: begin
                use_rs1 = 1'b0;
            end
            // Unknown opcodes behave like OP_IMM
            default: begin
                use_rs1 = 1'b1;
            end
        endcase
        // Writes to x0 are discarded, so no rename is needed
        if (inst.r.rd == '0) begin
            has_rd = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= accept;
        end
    end

    // Fields hold until the next accepted instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            dec_rs1     <= inst.r.rs1;
            dec_rs2     <= inst.r.rs2;
            dec_rd      <= has_rd ? inst.r.rd : '0;
            dec_use_rs1 <= use_rs1;
            dec_use_rs2 <= use_rs2;
            dec_has_rd  <= has_rd;
        end
    end

endmodule

//--- design/rename_map.sv
module rename_map #(
    parameter int  PR_ENTRIES = 64,
    parameter int  ROB_DEPTH  = 8,
    localparam int PR_W       = rename_pkg::preg_w(PR_ENTRIES),
    localparam int ROB_W      = rename_pkg::preg_w(ROB_DEPTH)
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          dec_valid,
    input  logic [rename_pkg::AREG_W-1:0] dec_rs1,
    input  logic [rename_pkg::AREG_W-1:0] dec_rs2,
    input  logic [rename_pkg::AREG_W-1:0] dec_rd,
    input  logic                          dec_use_rs1,
    input  logic                          dec_use_rs2,
    input  logic                          dec_has_rd,
    input  logic [PR_W-1:0]               free_head,
    input  logic [ROB_W-1:0]              rob_tail_id,
    output logic                          alloc,
    output logic                          rob_alloc,
    output logic [PR_W-1:0]               old_prd,
    output logic                          ren_valid,
    output logic                          ren_has_rd,
    output logic [PR_W-1:0]               ren_prs1,
    output logic [PR_W-1:0]               ren_prs2,
    output logic [PR_W-1:0]               ren_prd,
    output logic [PR_W-1:0]               ren_old_prd,
    output logic [ROB_W-1:0]              ren_rob_id
);

    // Register alias table, one physical index per architectural register
    logic [PR_W-1:0] rat [rename_pkg::AREG_COUNT];

    logic [PR_W-1:0] prs1;
    logic [PR_W-1:0] prs2;
    logic [PR_W-1:0] prd;

    assign prs1    = dec_use_rs1 ? rat[dec_rs1] : '0;
    assign prs2    = dec_use_rs2 ? rat[dec_rs2] : '0;
    assign prd     = dec_has_rd ? free_head : '0;
    assign old_prd = dec_has_rd ? rat[dec_rd] : '0;

    // Every decoded instruction takes a ROB slot, only writers take a register
    assign rob_alloc = dec_valid;
    assign alloc     = dec_valid && dec_has_rd;

    // Sources above read the old table, the new mapping lands on this edge
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::AREG_COUNT; i++) begin
                rat[i] <= PR_W'(rename_pkg::reset_map(i));
            end
        end else if (alloc) begin
            rat[dec_rd] <= free_head;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ren_valid <= 1'b0;
        end else begin
            ren_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ren_has_rd  <= dec_has_rd;
            ren_prs1    <= prs1;
            ren_prs2    <= prs2;
            ren_prd     <= prd;
            ren_old_prd <= old_prd;
            ren_rob_id  <= rob_tail_id;
        end
    end

    // Decode must never hand over x0 as a destination to rename
    a_no_x0_alloc: assert property (@(posedge clk) disable iff (rst)
        alloc |-> dec_rd != '0)
        else $error("physical register allocated for x0");

endmodule

//--- design/free_list.sv
module free_list #(
    parameter int  PR_ENTRIES = 64,
    localparam int PR_W       = rename_pkg::preg_w(PR_ENTRIES)
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            alloc,
    input  logic            commit_valid,
    input  logic            commit_has_rd,
    input  logic [PR_W-1:0] commit_old_prd,
    output logic [PR_W-1:0] free_head,
    output logic            free_avail
);

    // Registers left over once every architectural register is mapped
    localparam int FL_INIT = PR_ENTRIES - rename_pkg::AREG_COUNT;

    // Sized to PR_ENTRIES so the pointers wrap on their own
    logic [PR_W-1:0] fifo [PR_ENTRIES];
    logic [PR_W-1:0] head;
    logic [PR_W-1:0] tail;
    logic [PR_W:0]   count;
    logic            push;
    logic            pop;

    assign pop  = alloc;
    assign push = commit_valid && commit_has_rd;

    assign free_head = fifo[head];

    // Two spare entries cover the instruction held in decode
    assign free_avail = count >= (PR_W+1)'(2);

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= PR_W'(FL_INIT);
            count <= (PR_W+1)'(FL_INIT);
            for (int i = 0; i < FL_INIT; i++) begin
                fifo[i] <= PR_W'(rename_pkg::reset_free(i));
            end
        end else begin
            if (push) begin
                fifo[tail] <= commit_old_prd;
                tail       <= tail + PR_W'(1);
            end
            if (pop) begin
                head <= head + PR_W'(1);
            end
            count <= count + (PR_W+1)'(push) - (PR_W+1)'(pop);
        end
    end

    // Back-pressure from decode should keep the list from running dry
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> count != '0)
        else $error("free list popped while empty");

    // Only displaced registers come back, so the list never overfills
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        push |-> count != (PR_W+1)'(PR_ENTRIES))
        else $error("free list pushed while full");

endmodule

//--- design/reorder_buffer.sv
module reorder_buffer #(
    parameter int  PR_ENTRIES = 64,
    parameter int  ROB_DEPTH  = 8,
    localparam int PR_W       = rename_pkg::preg_w(PR_ENTRIES),
    localparam int ROB_W      = rename_pkg::preg_w(ROB_DEPTH)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             rob_alloc,
    input  logic             has_rd,
    input  logic [PR_W-1:0]  old_prd,
    input  logic             commit,
    output logic [ROB_W-1:0] rob_tail_id,
    output logic             rob_avail,
    output logic             commit_valid,
    output logic             commit_has_rd,
    output logic [PR_W-1:0]  commit_old_prd
);

    // Per entry payload, what retirement needs to release
    logic             ent_has_rd [ROB_DEPTH];
    logic [PR_W-1:0]  ent_old_prd [ROB_DEPTH];

    logic [ROB_W-1:0] head;
    logic [ROB_W-1:0] tail;
    logic [ROB_W:0]   count;
    logic             retire;

    assign rob_tail_id = tail;

    // Commit on an empty buffer is dropped
    assign retire       = commit && (count != '0);
    assign commit_valid = retire;

    assign commit_has_rd  = ent_has_rd[head];
    assign commit_old_prd = ent_old_prd[head];

    // Leave room for one instruction already past the stall check
    assign rob_avail = count <= (ROB_W+1)'(ROB_DEPTH - 2);

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (rob_alloc) begin
                tail <= tail + ROB_W'(1);
            end
            if (retire) begin
                head <= head + ROB_W'(1);
            end
            count <= count + (ROB_W+1)'(rob_alloc) - (ROB_W+1)'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (rob_alloc) begin
            ent_has_rd[tail]  <= has_rd;
            ent_old_prd[tail] <= old_prd;
        end
    end

    // The stall margin in decode must keep allocation off a full buffer
    a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
        rob_alloc |-> count != (ROB_W+1)'(ROB_DEPTH))
        else $error("ROB allocated while full");

endmodule

//--- design/rename_top.sv
module rename_top #(
    parameter int  PR_ENTRIES = 64,
    parameter int  ROB_DEPTH  = 8,
    localparam int PR_W       = rename_pkg::preg_w(PR_ENTRIES),
    localparam int ROB_W      = rename_pkg::preg_w(ROB_DEPTH)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid,
    input  rename_pkg::inst_u inst,
    input  logic              commit,
    output logic              stall,
    output logic              ren_valid,
    output logic [PR_W-1:0]   ren_prs1,
    output logic [PR_W-1:0]   ren_prs2,
    output logic [PR_W-1:0]   ren_prd,
    output logic [PR_W-1:0]   ren_old_prd,
    output logic [ROB_W-1:0]  ren_rob_id,
    output logic              ren_has_rd,
    output logic              commit_valid,
    output logic [PR_W-1:0]   commit_old_prd
);

    // Decode to rename
    logic                          dec_valid;
    logic [rename_pkg::AREG_W-1:0] dec_rs1;
    logic [rename_pkg::AREG_W-1:0] dec_rs2;
    logic [rename_pkg::AREG_W-1:0] dec_rd;
    logic                          dec_use_rs1;
    logic                          dec_use_rs2;
    logic                          dec_has_rd;

    // Rename to free list and ROB
    logic                          alloc;
    logic                          rob_alloc;
    logic [PR_W-1:0]               old_prd;
    logic [PR_W-1:0]               free_head;
    logic [ROB_W-1:0]              rob_tail_id;

    // Retirement and back-pressure
    logic                          commit_has_rd;
    logic                          free_avail;
    logic                          rob_avail;

    inst_decode u_inst_decode (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .free_avail  (free_avail),
        .rob_avail   (rob_avail),
        .stall       (stall),
        .dec_valid   (dec_valid),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_rd      (dec_rd),
        .dec_use_rs1 (dec_use_rs1),
        .dec_use_rs2 (dec_use_rs2),
        .dec_has_rd  (dec_has_rd)
    );

    rename_map #(
        .PR_ENTRIES (PR_ENTRIES),
        .ROB_DEPTH  (ROB_DEPTH)
    ) u_rename_map (
        .clk         (clk),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_rd      (dec_rd),
        .dec_use_rs1 (dec_use_rs1),
        .dec_use_rs2 (dec_use_rs2),
        .dec_has_rd  (dec_has_rd),
        .free_head   (free_head),
        .rob_tail_id (rob_tail_id),
        .alloc       (alloc),
        .rob_alloc   (rob_alloc),
        .old_prd     (old_prd),
        .ren_valid   (ren_valid),
        .ren_has_rd  (ren_has_rd),
        .ren_prs1    (ren_prs1),
        .ren_prs2    (ren_prs2),
        .ren_prd     (ren_prd),
        .ren_old_prd (ren_old_prd),
        .ren_rob_id  (ren_rob_id)
    );

    free_list #(
        .PR_ENTRIES (PR_ENTRIES)
    ) u_free_list (
        .clk            (clk),
        .rst            (rst),
        .alloc          (alloc),
        .commit_valid   (commit_valid),
        .commit_has_rd  (commit_has_rd),
        .commit_old_prd (commit_old_prd),
        .free_head      (free_head),
        .free_avail     (free_avail)
    );

    reorder_buffer #(
        .PR_ENTRIES (PR_ENTRIES),
        .ROB_DEPTH  (ROB_DEPTH)
    ) u_reorder_buffer (
        .clk            (clk),
        .rst            (rst),
        .rob_alloc      (rob_alloc),
        .has_rd         (dec_has_rd),
        .old_prd        (old_prd),
        .commit         (commit),
        .rob_tail_id    (rob_tail_id),
        .rob_avail      (rob_avail),
        .commit_valid   (commit_valid),
        .commit_has_rd  (commit_has_rd),
        .commit_old_prd (commit_old_prd)
    );

endmodule

//--- dv/rename_tb.sv
module rename_tb;

    localparam int PR_ENTRIES = 64;
    localparam int ROB_DEPTH  = 8;
    localparam int PR_W       = $clog2(PR_ENTRIES);
    localparam int ROB_W      = $clog2(ROB_DEPTH);
    localparam int N_ROWS     = 28;
    localparam int RAND_COUNT = 120;
    localparam int TIMEOUT    = 4 * (N_ROWS + RAND_COUNT) + 50;
    localparam int XLEN_W     = rename_pkg::XLEN_W;

    logic              clk;
    logic              rst;
    logic              inst_valid;
    rename_pkg::inst_u inst;
    logic              commit;
    logic              stall;
    logic              ren_valid;
    logic [PR_W-1:0]   ren_prs1;
    logic [PR_W-1:0]   ren_prs2;
    logic [PR_W-1:0]   ren_prd;
    logic [PR_W-1:0]   ren_old_prd;
    logic [ROB_W-1:0]  ren_rob_id;
    logic              ren_has_rd;
    logic              commit_valid;
    logic [PR_W-1:0]   commit_old_prd;

    // Stimulus table, one row per cycle slot
    logic              row_valid  [N_ROWS];
    logic              row_commit [N_ROWS];
    logic [XLEN_W-1:0] row_inst   [N_ROWS];
    int                fill_idx;

    // Reference model of the alias table, free list and ROB
    logic [PR_W-1:0]   m_rat [rename_pkg::AREG_COUNT];
    logic [PR_W-1:0]   m_free [$];
    logic              m_rob_has [$];
    logic [PR_W-1:0]   m_rob_old [$];
    int                m_rob_tail;

    // Instruction sitting in the decode register
    logic              d_valid;
    logic              d_use1;
    logic              d_use2;
    logic              d_has;
    logic [4:0]        d_rs1;
    logic [4:0]        d_rs2;
    logic [4:0]        d_rd;

    // Expected rename outputs
    logic              e_valid;
    logic              e_has;
    logic [PR_W-1:0]   e_prs1;
    logic [PR_W-1:0]   e_prs2;
    logic [PR_W-1:0]   e_prd;
    logic [PR_W-1:0]   e_old;
    int                e_rob_id;

    logic [31:0]       rand_state;
    int                cycle_count;

    rename_top #(
        .PR_ENTRIES (PR_ENTRIES),
        .ROB_DEPTH  (ROB_DEPTH)
    ) u_rename_top (
        .clk            (clk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .commit         (commit),
        .stall          (stall),
        .ren_valid      (ren_valid),
        .ren_prs1       (ren_prs1),
        .ren_prs2       (ren_prs2),
        .ren_prd        (ren_prd),
        .ren_old_prd    (ren_old_prd),
        .ren_rob_id     (ren_rob_id),
        .ren_has_rd     (ren_has_rd),
        .commit_valid   (commit_valid),
        .commit_old_prd (commit_old_prd)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the test did not finish within %0d cycles", TIMEOUT);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    function automatic logic [XLEN_W-1:0] enc_r(
        input logic [6:0] opc,
        input logic [4:0] rd,
        input logic [4:0] rs1,
        input logic [4:0] rs2
    );
        return {7'h00, rs2, rs1, 3'b000, rd, opc};
    endfunction

    // Immediate split around the source fields, as in STORE and BRANCH
    function automatic logic [XLEN_W-1:0] enc_s(
        input logic [6:0]  opc,
        input logic [4:0]  rs1,
        input logic [4:0]  rs2,
        input logic [11:0] imm
    );
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc};
    endfunction

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic predict_stall();
        return !(m_free.size() >= 2 && m_rob_has.size() <= ROB_DEPTH - 2);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic add_row(input logic v, input logic c, input logic [XLEN_W-1:0] w);
        if (fill_idx < N_ROWS) begin
            row_valid[fill_idx]  = v;
            row_commit[fill_idx] = c;
            row_inst[fill_idx]   = w;
        end
        fill_idx++;
    endtask

    task automatic load_table();
        add_row(1'b0, 1'b1, '0);
        add_row(1'b1, 1'b0, enc_r(rename_pkg::OP, 5'd1, 5'd2, 5'd3));
        add_row(1'b1, 1'b0, enc_r(rename_pkg::OP, 5'd4, 5'd1, 5'd5));
        add_row(1'b1, 1'b0, enc_r(rename_pkg::OP_IMM, 5'd1, 5'd1, 5'd5));
        add_row(1'b1, 1'b0, enc_s(rename_pkg::STORE, 5'd1, 5'd4, 12'h0bf));
        add_row(1'b1, 1'b0, enc_s(rename_pkg::BRANCH, 5'd4, 5'd1, 12'h8a3));
        add_row(1'b1, 1'b0, enc_r(rename_pkg::OP, 5'd0, 5'd1, 5'd2));
        add_row(1'b1, 1'b0, enc_r(rename_pkg::LUI, 5'd6, 5'd9, 5'd17));
        add_row(1'b1, 1'b0, enc_r(rename_pkg::LOAD, 5'd7, 5'd6, 5'd4));
        // ROB fills here and the drain path takes over
        add_row(1'b1, 1'b0, enc_r(rename_pkg::OP, 5'd8, 5'd7, 5'd6));
        add_row(1'b1, 1'b1, enc_r(rename_pkg::OP, 5'd9, 5'd8, 5'd1));
        add_row(1'b0, 1'b1, '0);
        add_row(1'b0, 1'b1, '0);
        add_row(1'b1, 1'b1, enc_r(rename_pkg::OP, 5'd1, 5'd9, 5'd4));
        // SYSTEM opcode, decoded like OP_IMM
        add_row(1'b1, 1'b0, enc_r(7'b1110011, 5'd10, 5'd1, 5'd2));
        add_row(1'b1, 1'b1, enc_s(rename_pkg::STORE, 5'd9, 5'd1, 12'h000));
        add_row(1'b1, 1'b1, enc_r(rename_pkg::OP, 5'd3, 5'd3, 5'd3));
        add_row(1'b1, 1'b1, enc_r(rename_pkg::OP, 5'd3, 5'd3, 5'd3));
        add_row(1'b1, 1'b1, enc_r(rename_pkg::OP_IMM, 5'd3, 5'd3, 5'd1));
        add_row(1'b1, 1'b1, enc_r(rename_pkg::LOAD, 5'd0, 5'd3, 5'd0));
        // Drain the ROB, then keep committing on an empty one
        repeat (8) add_row(1'b0, 1'b1, '0);
    endtask

    task automatic reset_model();
        for (int i = 0; i < rename_pkg::AREG_COUNT; i++) begin
            m_rat[i] = PR_W'(i);
        end
        m_free.delete();
        for (int p = rename_pkg::AREG_COUNT; p < PR_ENTRIES; p++) begin
            m_free.push_back(PR_W'(p));
        end
        m_rob_has.delete();
        m_rob_old.delete();
        m_rob_tail = 0;
        d_valid    = 1'b0;
        e_valid    = 1'b0;
    endtask

    // Step the model across one rising edge
    task automatic advance_model(input logic accept, input logic [XLEN_W-1:0] w,
                                 input logic retire);
        logic            has;
        logic [PR_W-1:0] old;
        e_valid = d_valid;
        if (d_valid) begin
            e_has  = d_has;
            e_prs1 = d_use1 ? m_rat[d_rs1] : '0;
            e_prs2 = d_use2 ? m_rat[d_rs2] : '0;
            e_prd  = '0;
            e_old  = '0;
            if (d_has) begin
                e_prd       = m_free.pop_front();
                e_old       = m_rat[d_rd];
                m_rat[d_rd] = e_prd;
            end
            e_rob_id   = m_rob_tail;
            m_rob_tail = (m_rob_tail + 1) % ROB_DEPTH;
            m_rob_has.push_back(e_has);
            m_rob_old.push_back(e_old);
        end
        if (retire) begin
            has = m_rob_has.pop_front();
            old = m_rob_old.pop_front();
            if (has) begin
                m_free.push_back(old);
            end
        end
        d_valid = accept;
        if (accept) begin
            d_use1 = 1'b1;
            d_use2 = 1'b0;
            d_has  = 1'b1;
            case (w[6:0])
                rename_pkg::OP: d_use2 = 1'b1;
                rename_pkg::STORE, rename_pkg::BRANCH: begin
                    d_use2 = 1'b1;
                    d_has  = 1'b0;
                end
                rename_pkg::LUI: d_use1 = 1'b0;
                default: begin
                end
            endcase
            d_rs1 = w[19:15];
            d_rs2 = w[24:20];
            d_rd  = w[11:7];
            if (d_rd == 5'd0) begin
                d_has = 1'b0;
            end
        end
    endtask

    // One table slot, repeated with commit forced while the front end stalls
    task automatic issue(input logic v, input logic [XLEN_W-1:0] w, input logic c);
        logic done;
        logic go;
        logic drive_commit;
        logic retire;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            check_value("stall", stall, predict_stall());
            check_value("ren_valid", ren_valid, e_valid);
            if (e_valid) begin
                check_value("ren_has_rd", ren_has_rd, e_has);
                check_value("ren_prs1", ren_prs1, e_prs1);
                check_value("ren_prs2", ren_prs2, e_prs2);
                check_value("ren_prd", ren_prd, e_prd);
                check_value("ren_old_prd", ren_old_prd, e_old);
                check_value("ren_rob_id", ren_rob_id, e_rob_id);
            end
            go           = v && !predict_stall();
            drive_commit = (v && !go) ? 1'b1 : c;
            inst_valid   = go;
            inst         = w;
            commit       = drive_commit;
            done         = !v || go;
            #1;
            retire = drive_commit && (m_rob_has.size() != 0);
            check_value("commit_valid", commit_valid, retire);
            if (retire) begin
                check_value("commit_old_prd", commit_old_prd, m_rob_old[0]);
            end
            advance_model(go, w, retire);
        end
    endtask

    initial begin
        logic [31:0]       r;
        logic [XLEN_W-1:0] w;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        commit     = 1'b0;
        rand_state = 32'h9f11_a14c;
        fill_idx   = 0;
        reset_model();
        load_table();
        if (fill_idx != N_ROWS) begin
            $display("Stimulus table holds %0d rows instead of %0d", fill_idx, N_ROWS);
            $display("Simulation failed");
            $fatal(1, "table size");
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < N_ROWS; i++) begin
            issue(row_valid[i], row_inst[i], row_commit[i]);
        end

        // Random OP, STORE and LUI mix
        for (int n = 0; n < RAND_COUNT; n++) begin
            r = next_rand();
            case (r[31:24] % 3)
                0: w = enc_r(rename_pkg::OP, r[23:19], r[18:14], r[13:9]);
                1: w = enc_s(rename_pkg::STORE, r[18:14], r[13:9], {r[7:0], r[27:24]});
                default: w = enc_r(rename_pkg::LUI, r[23:19], r[18:14], r[13:9]);
            endcase
            issue(1'b1, w, r[8]);
        end

        repeat (3) issue(1'b0, '0, 1'b0);
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- filelist.f
design/rename_pkg.sv
design/inst_decode.sv
design/rename_map.sv
design/free_list.sv
design/reorder_buffer.sv
design/rename_top.sv
dv/rename_tb.sv

//--- Bender.yml
package:
  name: rename_front_end

sources:
  - files:
      - design/rename_pkg.sv
      - design/inst_decode.sv
      - design/rename_map.sv
      - design/free_list.sv
      - design/reorder_buffer.sv
      - design/rename_top.sv
  - target: test
    files:
      - dv/rename_tb.sv
